// File: mdu_pkg.sv
//--------------------
// Operand width is fixed at 32 bits
// Op codes follow the RISC-V M-extension funct3 field
//--------------------
package mdu_pkg;

    typedef logic [31:0] mdu_data_t;

    // funct3 encoding of the M extension
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } mdu_op_e;

    typedef struct packed {
        mdu_op_e   op;
        mdu_data_t rs1;
        mdu_data_t rs2;
    } mdu_req_t;

    // One-hot multiplier states
    typedef enum logic [2:0] {
        MS_IDLE = 3'b100,
        MS_MUL  = 3'b010,
        MS_DONE = 3'b001
    } mul_state_e;

    typedef enum logic [1:0] {
        DS_IDLE,
        DS_ITER,
        DS_FIX,
        DS_DONE
    } div_state_e;

    // Shift-and-subtract steps per division
    localparam int DIV_ITERS = 32;

endpackage

// File: mdu_mul.sv
//--------------------
// Done rises one edge after the start edge and holds under stall
// start must only be raised when the caller accepts a request
//--------------------
`timescale 1ns/1ps

module mdu_mul
    import mdu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        stall,
    input  logic        start,
    input  logic        a_signed,
    input  logic        b_signed,
    input  mdu_data_t   a,
    input  mdu_data_t   b,
    output logic [63:0] product,
    output logic        done
);

    mdu_data_t   a_abs;
    mdu_data_t   b_abs;
    logic        a_neg;
    logic        b_neg;
    logic        neg_r;
    logic [31:0] p_hh;
    logic [31:0] p_lh;
    logic [31:0] p_hl;
    logic [31:0] p_ll;
    logic [63:0] sum_abs;
    mul_state_e  state;
    mul_state_e  next;

    // Each operand has its own signedness for MULHSU
    assign a_neg = a_signed & a[31];
    assign b_neg = b_signed & b[31];
    assign a_abs = a_neg ? -a : a;
    assign b_abs = b_neg ? -b : b;

    assign sum_abs = {p_hh, 32'b0}
                   + {16'b0, p_lh, 16'b0}
                   + {16'b0, p_hl, 16'b0}
                   + {32'b0, p_ll};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= MS_IDLE;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next = state;
        if (flush) begin
            next = MS_IDLE;
        end else begin
            unique case (state)
                MS_IDLE: begin
                    if (start) next = MS_MUL;
                end
                MS_MUL: begin
                    next = MS_DONE;
                end
                MS_DONE: begin
                    if (!stall) begin
                        next = start ? MS_MUL : MS_IDLE;
                    end
                end
                default: next = MS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= (next == MS_DONE);
        end
    end

    // Stage one on entry to MUL, stage two on entry to DONE
    always_ff @(posedge clk) begin
        if (next == MS_MUL) begin
            p_hh  <= a_abs[31:16] * b_abs[31:16];
            p_lh  <= a_abs[15:0] * b_abs[31:16];
            p_hl  <= a_abs[31:16] * b_abs[15:0];
            p_ll  <= a_abs[15:0] * b_abs[15:0];
            neg_r <= a_neg ^ b_neg;
        end
        if (next == MS_DONE && state == MS_MUL) begin
            product <= neg_r ? -sum_abs : sum_abs;
        end
    end

endmodule

// File: mdu_div.sv
//--------------------
// Done rises 34 edges after the start edge and holds under stall
// Zero divisor and signed overflow take the same time
//--------------------
`timescale 1ns/1ps

module mdu_div
    import mdu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      stall,
    input  logic      start,
    input  logic      is_signed,
    input  mdu_data_t a,
    input  mdu_data_t b,
    output mdu_data_t quotient,
    output mdu_data_t remainder,
    output logic      done
);

    div_state_e state;
    div_state_e next;
    logic       load;
    logic [5:0] cnt;

    // Raw operands from the start edge
    mdu_data_t  a_q;
    mdu_data_t  b_q;
    logic       sgn_q;

    logic       sa_r;
    logic       sb_r;
    logic       dz_r;
    mdu_data_t  dsr_r;
    mdu_data_t  rem_r;
    mdu_data_t  q_r;
    logic [32:0] rem_sh;
    logic [32:0] diff;

    assign rem_sh = {rem_r, q_r[31]};
    assign diff   = rem_sh - {1'b0, dsr_r};

    assign load = (next == DS_ITER) && (state != DS_ITER);
    assign done = (state == DS_DONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= DS_IDLE;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next = state;
        if (flush) begin
            next = DS_IDLE;
        end else begin
            unique case (state)
                DS_IDLE: begin
                    if (start) next = DS_ITER;
                end
                DS_ITER: begin
                    if (cnt == 6'(DIV_ITERS)) next = DS_FIX;
                end
                DS_FIX: begin
                    next = DS_DONE;
                end
                DS_DONE: begin
                    if (!stall) begin
                        next = start ? DS_ITER : DS_IDLE;
                    end
                end
                default: next = DS_IDLE;
            endcase
        end
    end

    // First ITER cycle is setup, the next DIV_ITERS cycles iterate
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= '0;
        end else if (state == DS_ITER) begin
            cnt <= cnt + 6'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            a_q   <= a;
            b_q   <= b;
            sgn_q <= is_signed;
        end else if (state == DS_ITER) begin
            if (cnt == '0) begin
                sa_r  <= sgn_q & a_q[31];
                sb_r  <= sgn_q & b_q[31];
                dz_r  <= (b_q == '0);
                q_r   <= (sgn_q & a_q[31]) ? -a_q : a_q;
                dsr_r <= (sgn_q & b_q[31]) ? -b_q : b_q;
                rem_r <= '0;
            end else if (!diff[32]) begin
                rem_r <= diff[31:0];
                q_r   <= {q_r[30:0], 1'b1};
            end else begin
                rem_r <= rem_sh[31:0];
                q_r   <= {q_r[30:0], 1'b0};
            end
        end else if (state == DS_FIX) begin
            // Overflow needs no special case, -(2^31) wraps to itself
            if (dz_r) begin
                quotient <= '1;
            end else begin
                quotient <= (sa_r ^ sb_r) ? -q_r : q_r;
            end
            // Remainder follows the dividend, also for a zero divisor
            remainder <= sa_r ? -rem_r : rem_r;
        end
    end

endmodule

// File: mdu_top.sv
//--------------------
// One request at a time, ignored while busy
// Multiply done after 2 cycles, divide after 35
//--------------------
`timescale 1ns/1ps

module mdu_top
    import mdu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  mdu_req_t  req,
    input  logic      en,
    input  logic      stall,
    input  logic      flush,
    output mdu_data_t result,
    output logic      done,
    output logic      busy
);

    logic        accept;
    logic        start_mul;
    logic        start_div;
    logic        a_signed;
    logic        b_signed;
    logic        div_signed;
    logic        run_q;
    mdu_op_e     op_q;
    logic [63:0] product;
    logic        mul_done;
    mdu_data_t   quotient;
    mdu_data_t   remainder;
    logic        div_done;

    assign done = mul_done | div_done;
    assign busy = run_q & ~done;

    // New request when idle, or when the held result is released
    assign accept = en & ~flush & ((~busy & ~done) | (done & ~stall));

    // op[2] marks the divide group
    assign start_mul = accept & ~req.op[2];
    assign start_div = accept & req.op[2];

    always_comb begin
        a_signed   = 1'b0;
        b_signed   = 1'b0;
        div_signed = 1'b0;
        unique case (req.op)
            OP_MULH: begin
                a_signed = 1'b1;
                b_signed = 1'b1;
            end
            OP_MULHSU: a_signed = 1'b1;
            OP_DIV, OP_REM: div_signed = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q <= 1'b0;
            op_q  <= OP_MUL;
        end else if (flush) begin
            run_q <= 1'b0;
        end else if (accept) begin
            run_q <= 1'b1;
            op_q  <= req.op;
        end else if (done) begin
            run_q <= 1'b0;
        end
    end

    always_comb begin
        unique case (op_q)
            OP_MUL:                       result = product[31:0];
            OP_MULH, OP_MULHSU, OP_MULHU: result = product[63:32];
            OP_DIV, OP_DIVU:              result = quotient;
            default:                      result = remainder;
        endcase
    end

    mdu_mul u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .stall    (stall),
        .start    (start_mul),
        .a_signed (a_signed),
        .b_signed (b_signed),
        .a        (req.rs1),
        .b        (req.rs2),
        .product  (product),
        .done     (mul_done)
    );

    mdu_div u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .stall     (stall),
        .start     (start_div),
        .is_signed (div_signed),
        .a         (req.rs1),
        .b         (req.rs2),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (div_done)
    );

endmodule

// File: mdu_sva.sv
//--------------------
// Protocol checks on done, busy, stall and flush
//--------------------
`timescale 1ns/1ps

module mdu_sva
    import mdu_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      stall,
    input logic      flush,
    input logic      done,
    input logic      busy,
    input mdu_data_t result
);

    // done only ends an operation that was in progress
    done_after_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $past(busy)
    ) else $error("done rose without an operation in progress");

    // Result held under back-pressure
    stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (done && stall && !flush) |=> (done && $stable(result))
    ) else $error("result or done changed while stalled");

    flush_clears: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !done
    ) else $error("done high in the cycle after flush");

endmodule

bind mdu_top mdu_sva u_sva (
    .clk    (clk),
    .rst_n  (rst_n),
    .stall  (stall),
    .flush  (flush),
    .done   (done),
    .busy   (busy),
    .result (result)
);

// File: tb_mdu.sv
//--------------------
// Latency counts rising edges from the request drive to done
// Inputs change 1 ns after the rising edge, outputs sampled there too
//--------------------
`timescale 1ns/1ps

module tb_mdu
    import mdu_pkg::*;
();

    localparam int MUL_LAT    = 2;
    localparam int DIV_LAT    = 35;
    localparam int WAIT_LIMIT = 100;

    logic      clk;
    logic      rst_n;
    mdu_req_t  req;
    logic      en;
    logic      stall;
    logic      flush;
    mdu_data_t result;
    logic      done;
    logic      busy;

    int          errors;
    int          checks;

    mdu_data_t corners [0:4] = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF,
                                 32'h8000_0000, 32'h7FFF_FFFF};

    mdu_top u_mdu_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .en     (en),
        .stall  (stall),
        .flush  (flush),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_data(input string name, input mdu_data_t exp, input mdu_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("ERR %s latency: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // RISC-V M-extension results from 64-bit arithmetic
    function automatic mdu_data_t model(input mdu_op_e op, input mdu_data_t a,
                                        input mdu_data_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ub;
        logic signed [63:0] sp;
        logic [63:0]        up;
        mdu_data_t          res;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ub = {32'b0, b};
        case (op)
            OP_MUL: begin
                sp  = sa * sb;
                res = sp[31:0];
            end
            OP_MULH: begin
                sp  = sa * sb;
                res = sp[63:32];
            end
            OP_MULHSU: begin
                sp  = sa * ub;
                res = sp[63:32];
            end
            OP_MULHU: begin
                up  = {32'b0, a} * {32'b0, b};
                res = up[63:32];
            end
            OP_DIV: begin
                if (b == '0) begin
                    res = '1;
                end else if (a == 32'h8000_0000 && b == '1) begin
                    res = a;
                end else begin
                    sp  = sa / sb;
                    res = sp[31:0];
                end
            end
            OP_DIVU: res = (b == '0) ? '1 : a / b;
            OP_REM: begin
                if (b == '0) begin
                    res = a;
                end else begin
                    sp  = sa % sb;
                    res = sp[31:0];
                end
            end
            default: res = (b == '0) ? a : a % b;
        endcase
        return res;
    endfunction

    function automatic int latency_of(input mdu_op_e op);
        return (op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU}) ? DIV_LAT : MUL_LAT;
    endfunction

    task automatic wait_done(input string name, inout int edges);
        while (!done && edges < WAIT_LIMIT) begin
            next_cycle();
            edges++;
        end
        if (!done) begin
            errors++;
            $display("Timeout in %s: done did not rise within %0d cycles", name, WAIT_LIMIT);
        end
    endtask

    task automatic issue(input mdu_op_e op, input mdu_data_t a, input mdu_data_t b);
        req.op  = op;
        req.rs1 = a;
        req.rs2 = b;
        en      = 1'b1;
    endtask

    // Issues one request and checks latency and result
    task automatic run_op(input mdu_op_e op, input mdu_data_t a, input mdu_data_t b);
        string name;
        int    edges;
        name = $sformatf("%s %h %h", op.name(), a, b);
        issue(op, a, b);
        next_cycle();
        en    = 1'b0;
        edges = 1;
        wait_done(name, edges);
        if (done) begin
            check_latency(name, latency_of(op), edges);
            check_data(name, model(op, a, b), result);
        end
    endtask

    task automatic test_corners(input int first_op);
        mdu_op_e op;
        for (int k = first_op; k < first_op + 4; k++) begin
            op = mdu_op_e'(k[2:0]);
            foreach (corners[i]) begin
                foreach (corners[j]) begin
                    run_op(op, corners[i], corners[j]);
                end
            end
        end
    endtask

    task automatic test_mul_random();
        mdu_data_t a;
        mdu_data_t b;
        for (int n = 0; n < 40; n++) begin
            a = $urandom;
            b = $urandom;
            for (int k = 0; k < 4; k++) begin
                run_op(mdu_op_e'(k[2:0]), a, b);
            end
        end
    endtask

    task automatic test_div_random();
        mdu_data_t a;
        mdu_data_t b;
        for (int n = 0; n < 10; n++) begin
            a = $urandom;
            // Smaller divisors give quotients of many widths
            b = $urandom >> ($urandom % 32);
            for (int k = 4; k < 8; k++) begin
                run_op(mdu_op_e'(k[2:0]), a, b);
            end
        end
    endtask

    task automatic test_stall(input mdu_op_e op, input mdu_data_t a, input mdu_data_t b);
        string     name;
        int        edges;
        mdu_data_t held;
        name  = $sformatf("stall %s", op.name());
        stall = 1'b1;
        issue(op, a, b);
        next_cycle();
        en    = 1'b0;
        edges = 1;
        wait_done(name, edges);
        if (done) begin
            check_data(name, model(op, a, b), result);
            held = model(op, a, b);
            repeat (5) begin
                next_cycle();
                check_flag({name, " done"}, 1'b1, done);
                check_data({name, " held"}, held, result);
            end
            stall = 1'b0;
            next_cycle();
            check_flag({name, " release"}, 1'b0, done);
            check_flag({name, " busy"}, 1'b0, busy);
        end
        stall = 1'b0;
    endtask

    task automatic test_flush();
        issue(OP_DIV, 32'hDEAD_BEEF, 32'h0000_0123);
        next_cycle();
        en = 1'b0;
        repeat (10) next_cycle();
        check_flag("flush busy before", 1'b1, busy);
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        check_flag("flush busy after", 1'b0, busy);
        for (int i = 0; i < DIV_LAT + 5; i++) begin
            check_flag("flush done", 1'b0, done);
            next_cycle();
        end
        run_op(OP_MUL, 32'h1234_5678, 32'h9ABC_DEF0);
    endtask

    // Each request is issued in the cycle where the previous done is high
    task automatic test_back_to_back();
        for (int n = 0; n < 8; n++) begin
            run_op(mdu_op_e'(3'($urandom % 4)), $urandom, $urandom);
        end
    endtask

    task automatic test_ignore_busy();
        mdu_data_t a;
        mdu_data_t b;
        int        edges;
        a = $urandom;
        b = $urandom >> 8;
        issue(OP_DIVU, a, b);
        next_cycle();
        edges = 1;
        issue(OP_MUL, $urandom, $urandom);
        repeat (5) begin
            check_flag("ignore busy", 1'b1, busy);
            next_cycle();
            edges++;
        end
        en = 1'b0;
        wait_done("ignore", edges);
        if (done) begin
            check_latency("ignore", DIV_LAT, edges);
            check_data("ignore DIVU", model(OP_DIVU, a, b), result);
        end
    endtask

    initial begin
        void'($urandom(61475));
        errors = 0;
        checks = 0;
        rst_n  = 1'b0;
        req    = '0;
        en     = 1'b0;
        stall  = 1'b0;
        flush  = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        check_flag("reset done", 1'b0, done);
        check_flag("reset busy", 1'b0, busy);

        test_corners(0);
        test_mul_random();
        next_cycle();
        test_corners(4);
        test_div_random();
        next_cycle();
        test_stall(OP_MULHSU, 32'hFFFF_FFF0, 32'h0001_0003);
        test_stall(OP_REM, 32'h8000_0001, 32'h0000_0007);
        next_cycle();
        test_flush();
        test_back_to_back();
        next_cycle();
        test_ignore_busy();
        repeat (3) next_cycle();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: sim.f
mdu_pkg.sv
mdu_mul.sv
mdu_div.sv
mdu_top.sv
mdu_sva.sv
tb_mdu.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_mdu -o tb_mdu > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_mdu > sim.log 2>&1 || echo "Simulator returned an error"
grep -q "^NO ERRORS$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
